// File: logic/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path width
`define XLEN 32

// 16 instruction words and the PC width
`define IMEM_AW 4

// 8 data words
`define DMEM_AW 3

`endif

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3e,
		OP_OUT   = 6'h3f
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL
	} alu_op_e;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		alu_op_e alu_op;
		// second operand source
		logic use_imm;
		logic use_sa;
		logic branch_eq;
		logic branch_ne;
		logic jump;
		logic out_en;
		logic halt;
	} ctrl_t;

endpackage

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package pipe_pkg;

	typedef struct packed {
		logic [`IMEM_AW-1:0] pc;
		logic [31:0] inst;
	} fetch_t;

	typedef struct packed {
		isa_pkg::ctrl_t ctrl;
		logic [`XLEN-1:0] op1;
		logic [`XLEN-1:0] op2;
		logic [4:0] dest;
		logic [4:0] sa;
		// sign extended
		logic [`XLEN-1:0] imm;
		logic [`IMEM_AW-1:0] jump_target;
		logic [`IMEM_AW-1:0] pc;
	} operand_t;

	typedef struct packed {
		isa_pkg::ctrl_t ctrl;
		logic [`XLEN-1:0] alu_result;
		logic [`XLEN-1:0] store_data;
		logic [4:0] dest;
		// already resolved for branches and jumps
		logic [`IMEM_AW-1:0] next_pc;
	} exec_t;

	typedef struct packed {
		isa_pkg::ctrl_t ctrl;
		logic [`XLEN-1:0] alu_result;
		logic [`XLEN-1:0] load_data;
		logic [4:0] dest;
		logic [`IMEM_AW-1:0] next_pc;
		logic [7:0] out_byte;
	} mem_t;

	typedef struct packed {
		logic en;
		logic [4:0] addr;
		logic [`XLEN-1:0] data;
	} reg_write_t;

endpackage

`default_nettype wire

// File: logic/inst_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module inst_fetch (
	input logic CLK,
	input logic reset,
	input logic load_start,
	input logic load_valid,
	input logic [7:0] load_data,
	input logic load_end,
	input logic fetch_start,
	input logic [`IMEM_AW-1:0] next_pc,
	output logic fetch_valid,
	output pipe_pkg::fetch_t fetch
);

	logic [31:0] imem [0:(1<<`IMEM_AW)-1];
	logic [`IMEM_AW-1:0] load_ptr;
	logic [1:0] byte_cnt;
	// first three bytes of the word being loaded
	logic [23:0] word_buf;

	// loader position
	always_ff @(posedge CLK) begin
		if (reset || load_start) begin
			load_ptr <= '0;
			byte_cnt <= '0;
		end else if (load_valid) begin
			byte_cnt <= byte_cnt + 2'd1;
			if (byte_cnt == 2'd3) begin
				load_ptr <= load_ptr + 1'b1;
			end
		end
	end

	// little endian order with the newest byte entering at the top
	always_ff @(posedge CLK) begin
		if (load_valid && !load_start) begin
			word_buf <= {load_data, word_buf[23:8]};
			if (byte_cnt == 2'd3) begin
				imem[load_ptr] <= {load_data, word_buf};
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= load_end || fetch_start;
		end
	end

	// load_end always starts the program at word 0
	always_ff @(posedge CLK) begin
		if (load_end) begin
			fetch.pc <= '0;
			fetch.inst <= imem[0];
		end else if (fetch_start) begin
			fetch.pc <= next_pc;
			fetch.inst <= imem[next_pc];
		end
	end

endmodule

`default_nettype wire

// File: logic/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module inst_decode (
	input logic decode_valid,
	input pipe_pkg::fetch_t decode_data,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output isa_pkg::ctrl_t ctrl,
	output pipe_pkg::operand_t fields,
	output logic operand_start
);
	import isa_pkg::*;

	opcode_e opcode;
	funct_e funct;
	logic [4:0] rd;
	logic [15:0] imm16;

	assign opcode = opcode_e'(decode_data.inst[31:26]);
	assign funct = funct_e'(decode_data.inst[5:0]);
	assign rd = decode_data.inst[15:11];
	assign imm16 = decode_data.inst[15:0];
	assign rs = decode_data.inst[25:21];
	// OUT reads r0 as op2 so the ALU passes rs through
	assign rt = (opcode == OP_OUT) ? 5'd0 : decode_data.inst[20:16];
	assign operand_start = decode_valid;

	// unknown opcode or funct leaves everything off
	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				case (funct)
					F_ADDU: ctrl.alu_op = ALU_ADD;
					F_SUBU: ctrl.alu_op = ALU_SUB;
					F_AND: ctrl.alu_op = ALU_AND;
					F_OR: ctrl.alu_op = ALU_OR;
					F_SLT: ctrl.alu_op = ALU_SLT;
					F_SLL: begin
						ctrl.alu_op = ALU_SLL;
						ctrl.use_sa = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
			end
			OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.use_imm = 1'b1;
			end
			OP_SW: begin
				ctrl.mem_write = 1'b1;
				ctrl.use_imm = 1'b1;
			end
			OP_BEQ: ctrl.branch_eq = 1'b1;
			OP_BNE: ctrl.branch_ne = 1'b1;
			OP_J: ctrl.jump = 1'b1;
			OP_OUT: ctrl.out_en = 1'b1;
			OP_HALT: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		fields = '0;
		fields.ctrl = ctrl;
		fields.dest = (opcode == OP_RTYPE) ? rd : decode_data.inst[20:16];
		fields.sa = decode_data.inst[10:6];
		fields.imm = {{(`XLEN-16){imm16[15]}}, imm16};
		fields.jump_target = decode_data.inst[`IMEM_AW-1:0];
		fields.pc = decode_data.pc;
	end

endmodule

`default_nettype wire

// File: logic/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module operand_fetch (
	input logic CLK,
	input logic operand_start,
	input logic [4:0] rs,
	input logic [4:0] rt,
	input pipe_pkg::operand_t fields,
	input pipe_pkg::reg_write_t wr,
	output logic operand_valid,
	output pipe_pkg::operand_t operand
);

	logic [`XLEN-1:0] regs [0:31];
	logic [`XLEN-1:0] rs_value;
	logic [`XLEN-1:0] rt_value;

	// r0 is never stored
	always_ff @(posedge CLK) begin
		if (wr.en && wr.addr != 5'd0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// register 0 reads as zero
	assign rs_value = (rs == 5'd0) ? '0 : regs[rs];
	assign rt_value = (rt == 5'd0) ? '0 : regs[rt];

	// one cycle behind operand_start
	always_ff @(posedge CLK) begin
		operand_valid <= operand_start;
	end

	always_ff @(posedge CLK) begin
		if (operand_start) begin
			operand <= fields;
			operand.op1 <= rs_value;
			operand.op2 <= rt_value;
		end
	end

endmodule

`default_nettype wire

// File: logic/execution.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module execution (
	input logic CLK,
	input logic reset,
	input logic operand_valid,
	input pipe_pkg::operand_t operand,
	output logic exec_valid,
	output pipe_pkg::exec_t exec
);
	import isa_pkg::*;

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] alu_result;
	logic taken;
	logic [`IMEM_AW-1:0] pc_inc;
	logic [`IMEM_AW-1:0] next_pc;

	// SLL shifts rt while everything else starts from rs
	assign a = operand.ctrl.use_sa ? operand.op2 : operand.op1;
	assign b = operand.ctrl.use_imm ? operand.imm :
		operand.ctrl.use_sa ? {{(`XLEN-5){1'b0}}, operand.sa} : operand.op2;

	always_comb begin
		case (operand.ctrl.alu_op)
			ALU_ADD: alu_result = a + b;
			ALU_SUB: alu_result = a - b;
			ALU_AND: alu_result = a & b;
			ALU_OR: alu_result = a | b;
			ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLL: alu_result = a << b[4:0];
			default: alu_result = '0;
		endcase
	end

	assign taken = (operand.ctrl.branch_eq && operand.op1 == operand.op2) ||
		(operand.ctrl.branch_ne && operand.op1 != operand.op2);

	// target wraps around the instruction memory
	assign pc_inc = operand.pc + 1'b1;
	assign next_pc = operand.ctrl.jump ? operand.jump_target :
		taken ? pc_inc + operand.imm[`IMEM_AW-1:0] : pc_inc;

	always_ff @(posedge CLK) begin
		if (reset) begin
			exec_valid <= 1'b0;
		end else begin
			exec_valid <= operand_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (operand_valid) begin
			exec.ctrl <= operand.ctrl;
			exec.alu_result <= alu_result;
			exec.store_data <= operand.op2;
			exec.dest <= operand.dest;
			exec.next_pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// File: logic/memory_access.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module memory_access (
	input logic CLK,
	input logic reset,
	input logic exec_valid,
	input pipe_pkg::exec_t exec,
	output logic mem_valid,
	output pipe_pkg::mem_t mem
);

	logic [`XLEN-1:0] dmem [0:(1<<`DMEM_AW)-1];
	logic [`DMEM_AW-1:0] addr;

	// word address wraps to the data memory size
	assign addr = exec.alu_result[`DMEM_AW+1:2];

	always_ff @(posedge CLK) begin
		if (reset) begin
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= exec_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exec_valid) begin
			if (exec.ctrl.mem_write) begin
				dmem[addr] <= exec.store_data;
			end
			mem.ctrl <= exec.ctrl;
			mem.alu_result <= exec.alu_result;
			mem.load_data <= dmem[addr];
			mem.dest <= exec.dest;
			mem.next_pc <= exec.next_pc;
			// for OUT the ALU result is rs
			mem.out_byte <= exec.alu_result[7:0];
		end
	end

endmodule

`default_nettype wire

// File: logic/write_back_pc_generate.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module write_back_pc_generate (
	input logic CLK,
	input logic reset,
	input logic mem_valid,
	input pipe_pkg::mem_t mem,
	output pipe_pkg::reg_write_t wr,
	output logic fetch_start,
	output logic [`IMEM_AW-1:0] next_pc,
	output logic out_valid,
	output logic [7:0] out_data,
	output logic halted
);

	// register file writes at the end of the mem_valid cycle
	assign wr.en = mem_valid && mem.ctrl.reg_write;
	assign wr.addr = mem.dest;
	assign wr.data = mem.ctrl.mem_read ? mem.load_data : mem.alu_result;

	// HALT stops issuing
	assign fetch_start = mem_valid && !mem.ctrl.halt;
	assign next_pc = mem.next_pc;

	always_ff @(posedge CLK) begin
		if (reset) begin
			out_valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			out_valid <= mem_valid && mem.ctrl.out_en;
			if (mem_valid && mem.ctrl.halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (mem_valid && mem.ctrl.out_en) begin
			out_data <= mem.out_byte;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu_top (
	input logic CLK,
	input logic reset,
	input logic load_start,
	input logic load_valid,
	input logic [7:0] load_data,
	input logic load_end,
	output logic out_valid,
	output logic [7:0] out_data,
	output logic halted
);
	import pipe_pkg::*;

	logic fetch_valid;
	fetch_t fetch;
	logic decode_valid;
	fetch_t decode_data;
	logic [4:0] rs;
	logic [4:0] rt;
	operand_t fields;
	logic operand_start;
	logic operand_valid;
	operand_t operand;
	logic exec_valid;
	exec_t exec;
	logic mem_valid;
	mem_t mem;
	reg_write_t wr;
	logic fetch_start;
	logic [`IMEM_AW-1:0] next_pc;

	inst_fetch inst_fetch_instance (
		.CLK(CLK),
		.reset(reset),
		.load_start(load_start),
		.load_valid(load_valid),
		.load_data(load_data),
		.load_end(load_end),
		.fetch_start(fetch_start),
		.next_pc(next_pc),
		.fetch_valid(fetch_valid),
		.fetch(fetch)
	);

	// decode token
	always_ff @(posedge CLK) begin
		if (reset) begin
			decode_valid <= 1'b0;
		end else begin
			decode_valid <= fetch_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_valid) begin
			decode_data <= fetch;
		end
	end

	// control also travels inside fields
	inst_decode inst_decode_instance (
		.decode_valid(decode_valid),
		.decode_data(decode_data),
		.rs(rs),
		.rt(rt),
		.ctrl(),
		.fields(fields),
		.operand_start(operand_start)
	);

	operand_fetch operand_fetch_instance (
		.CLK(CLK),
		.operand_start(operand_start),
		.rs(rs),
		.rt(rt),
		.fields(fields),
		.wr(wr),
		.operand_valid(operand_valid),
		.operand(operand)
	);

	execution execution_instance (
		.CLK(CLK),
		.reset(reset),
		.operand_valid(operand_valid),
		.operand(operand),
		.exec_valid(exec_valid),
		.exec(exec)
	);

	memory_access memory_access_instance (
		.CLK(CLK),
		.reset(reset),
		.exec_valid(exec_valid),
		.exec(exec),
		.mem_valid(mem_valid),
		.mem(mem)
	);

	write_back_pc_generate write_back_pc_generate_instance (
		.CLK(CLK),
		.reset(reset),
		.mem_valid(mem_valid),
		.mem(mem),
		.wr(wr),
		.fetch_start(fetch_start),
		.next_pc(next_pc),
		.out_valid(out_valid),
		.out_data(out_data),
		.halted(halted)
	);

endmodule

`default_nettype wire

// File: verification/cpu_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_asserts (
	input logic CLK,
	input logic reset,
	input logic out_valid,
	input logic halted
);

	// nothing is emitted once stopped
	assert property (@(posedge CLK) disable iff (reset) halted |-> !out_valid)
		else $error("out_valid high while halted");

	// only reset clears halted
	assert property (@(posedge CLK) !reset && $past(!reset) |-> !$fell(halted))
		else $error("halted fell without reset");

	// output strobe is a single cycle
	assert property (@(posedge CLK) disable iff (reset) out_valid |=> !out_valid)
		else $error("out_valid high for two cycles");

endmodule

bind cpu_top cpu_asserts cpu_asserts_instance (
	.CLK(CLK),
	.reset(reset),
	.out_valid(out_valid),
	.halted(halted)
);

`default_nettype wire

// File: verification/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;
	import isa_pkg::*;

	localparam int IMEM_WORDS = 1 << `IMEM_AW;

	logic CLK = 1'b0;
	logic reset;
	logic load_start;
	logic load_valid;
	logic [7:0] load_data;
	logic load_end;
	logic out_valid;
	logic [7:0] out_data;
	logic halted;

	logic [31:0] prog [0:IMEM_WORDS-1];
	// expected bytes of every program run so far
	logic [7:0] exp_all [$];
	int out_count = 0;
	int seed = 52;

	cpu_top dut0 (
		.CLK(CLK),
		.reset(reset),
		.load_start(load_start),
		.load_valid(load_valid),
		.load_data(load_data),
		.load_end(load_end),
		.out_valid(out_valid),
		.out_data(out_data),
		.halted(halted)
	);

	always #2 CLK = ~CLK;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			stop_run($sformatf("FAIL %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, want));
		end
	endtask

	function automatic logic [31:0] rtype_word(input logic [5:0] funct, input int rs,
		input int rt, input int rd, input int sa);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sa[4:0], funct};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input int rs,
		input int rt, input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] jump_word(input int target);
		return {OP_J, target[25:0]};
	endfunction

	function automatic logic [31:0] halt_word();
		return {OP_HALT, 26'd0};
	endfunction

	// ISA model that returns the number of executed instructions up to HALT
	function automatic int run_model();
		logic [31:0] regs [0:31];
		logic [31:0] dmem [0:(1<<`DMEM_AW)-1];
		logic [31:0] inst;
		logic [31:0] simm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [`IMEM_AW-1:0] pc;
		logic [`IMEM_AW-1:0] pc_next;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < (1 << `DMEM_AW); i++) dmem[i] = '0;
		pc = '0;
		for (int steps = 1; steps <= 200; steps++) begin
			inst = prog[pc];
			rt = inst[20:16];
			rd = inst[15:11];
			simm = {{16{inst[15]}}, inst[15:0]};
			a = regs[inst[25:21]];
			b = regs[rt];
			ea = a + simm;
			pc_next = pc + 1'b1;
			case (inst[31:26])
				OP_RTYPE: begin
					case (inst[5:0])
						F_ADDU: regs[rd] = a + b;
						F_SUBU: regs[rd] = a - b;
						F_AND: regs[rd] = a & b;
						F_OR: regs[rd] = a | b;
						F_SLT: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						F_SLL: regs[rd] = b << inst[10:6];
						default: ;
					endcase
				end
				OP_ADDIU: regs[rt] = ea;
				OP_LW: regs[rt] = dmem[ea[`DMEM_AW+1:2]];
				OP_SW: dmem[ea[`DMEM_AW+1:2]] = b;
				OP_BEQ: if (a == b) pc_next = pc + 1'b1 + simm[`IMEM_AW-1:0];
				OP_BNE: if (a != b) pc_next = pc + 1'b1 + simm[`IMEM_AW-1:0];
				OP_J: pc_next = inst[`IMEM_AW-1:0];
				OP_OUT: exp_all.push_back(a[7:0]);
				OP_HALT: return steps;
				default: ;
			endcase
			regs[0] = '0;
			pc = pc_next;
		end
		return -1;
	endfunction

	task automatic clear_program();
		for (int i = 0; i < IMEM_WORDS; i++) prog[i] = '0;
	endtask

	task automatic build_alu_program();
		int v1;
		int v2;
		int sa;
		v1 = $random(seed);
		v2 = $random(seed);
		sa = $random(seed);
		clear_program();
		prog[0] = itype_word(OP_ADDIU, 0, 1, v1);
		prog[1] = itype_word(OP_ADDIU, 0, 2, v2);
		prog[2] = rtype_word(F_ADDU, 1, 2, 3, 0);
		prog[3] = itype_word(OP_OUT, 3, 0, 0);
		prog[4] = rtype_word(F_SUBU, 1, 2, 4, 0);
		prog[5] = itype_word(OP_OUT, 4, 0, 0);
		prog[6] = rtype_word(F_AND, 1, 2, 5, 0);
		prog[7] = itype_word(OP_OUT, 5, 0, 0);
		prog[8] = rtype_word(F_OR, 1, 2, 6, 0);
		prog[9] = itype_word(OP_OUT, 6, 0, 0);
		prog[10] = rtype_word(F_SLT, 1, 2, 7, 0);
		prog[11] = itype_word(OP_OUT, 7, 0, 0);
		prog[12] = rtype_word(F_SLL, 0, 2, 8, sa & 7);
		prog[13] = itype_word(OP_OUT, 8, 0, 0);
		prog[14] = halt_word();
	endtask

	// offsets chosen so that several addresses wrap around data memory
	task automatic build_memory_program();
		int v1;
		int v2;
		v1 = $random(seed);
		v2 = $random(seed);
		clear_program();
		prog[0] = itype_word(OP_ADDIU, 0, 1, v1);
		prog[1] = itype_word(OP_ADDIU, 0, 2, v2);
		prog[2] = itype_word(OP_SW, 0, 1, 8);
		prog[3] = itype_word(OP_SW, 0, 2, 44);
		prog[4] = itype_word(OP_LW, 0, 3, 12);
		prog[5] = itype_word(OP_LW, 0, 4, 40);
		prog[6] = itype_word(OP_OUT, 3, 0, 0);
		prog[7] = itype_word(OP_OUT, 4, 0, 0);
		prog[8] = itype_word(OP_ADDIU, 0, 5, 20);
		prog[9] = itype_word(OP_SW, 5, 1, -4);
		prog[10] = itype_word(OP_LW, 0, 6, 48);
		prog[11] = itype_word(OP_OUT, 6, 0, 0);
		prog[12] = itype_word(OP_SW, 5, 2, 8);
		prog[13] = itype_word(OP_LW, 0, 7, -4);
		prog[14] = itype_word(OP_OUT, 7, 0, 0);
		prog[15] = halt_word();
	endtask

	task automatic build_branch_program();
		clear_program();
		prog[0] = itype_word(OP_ADDIU, 0, 1, 5);
		prog[1] = itype_word(OP_ADDIU, 0, 2, 5);
		prog[2] = itype_word(OP_ADDIU, 0, 3, 7);
		prog[3] = itype_word(OP_BEQ, 1, 2, 1);
		prog[4] = itype_word(OP_OUT, 3, 0, 0);
		prog[5] = itype_word(OP_BNE, 1, 3, 1);
		prog[6] = itype_word(OP_OUT, 1, 0, 0);
		prog[7] = itype_word(OP_BEQ, 1, 3, 1);
		prog[8] = itype_word(OP_OUT, 3, 0, 0);
		prog[9] = itype_word(OP_BNE, 1, 2, 1);
		prog[10] = jump_word(13);
		prog[11] = itype_word(OP_OUT, 1, 0, 0);
		prog[12] = halt_word();
		prog[13] = itype_word(OP_OUT, 2, 0, 0);
		// backward branch onto the HALT
		prog[14] = itype_word(OP_BEQ, 0, 0, -3);
	endtask

	task automatic build_zero_program();
		clear_program();
		prog[0] = itype_word(OP_ADDIU, 0, 0, 'h55);
		prog[1] = itype_word(OP_OUT, 0, 0, 0);
		prog[2] = itype_word(OP_ADDIU, 0, 1, 'h3c);
		prog[3] = rtype_word(F_ADDU, 1, 1, 0, 0);
		prog[4] = itype_word(OP_OUT, 0, 0, 0);
		prog[5] = itype_word(6'h3a, 1, 1, 'h1234);
		prog[6] = itype_word(OP_OUT, 1, 0, 0);
		prog[7] = rtype_word(6'h3f, 1, 1, 1, 0);
		prog[8] = itype_word(OP_OUT, 1, 0, 0);
		prog[9] = halt_word();
		prog[10] = itype_word(OP_OUT, 1, 0, 0);
	endtask

	task automatic reset_dut();
		@(posedge CLK);
		reset <= 1'b1;
		repeat (3) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);
		check("out_valid", 32'(out_valid), 32'd0);
		check("halted", 32'(halted), 32'd0);
	endtask

	// returns at the edge that samples load_end
	task automatic load_program();
		@(posedge CLK);
		load_start <= 1'b1;
		@(posedge CLK);
		load_start <= 1'b0;
		for (int w = 0; w < IMEM_WORDS; w++) begin
			for (int b = 0; b < 4; b++) begin
				load_valid <= 1'b1;
				load_data <= prog[w][8*b +: 8];
				@(posedge CLK);
				check("halted", 32'(halted), 32'd0);
				check("out_valid", 32'(out_valid), 32'd0);
			end
		end
		load_valid <= 1'b0;
		load_end <= 1'b1;
		@(posedge CLK);
		load_end <= 1'b0;
	endtask

	task automatic run_program(input string label);
		int steps;
		int cycles;
		steps = run_model();
		if (steps < 0) stop_run({label, ": reference model never reached HALT"});
		load_program();
		cycles = 1;
		while (!halted && cycles < 500) begin
			@(posedge CLK);
			cycles++;
		end
		if (!halted) stop_run({label, ": timeout waiting for halted"});
		// five cycles per instruction plus two until halted is sampled
		check("halt cycle", cycles, 5 * steps + 2);
		repeat (10) @(posedge CLK);
		check("output count", out_count, exp_all.size());
		check("halted", 32'(halted), 32'd1);
	endtask

	// compare every emitted byte with the model
	always @(posedge CLK) begin
		if (out_valid) begin
			if (out_count >= exp_all.size()) begin
				stop_run("output byte emitted that the model does not predict");
			end else begin
				check("out_data", 32'(out_data), 32'(exp_all[out_count]));
				out_count++;
			end
		end
	end

	initial begin
		int round;
		reset = 1'b1;
		load_start = 1'b0;
		load_valid = 1'b0;
		load_data = 8'd0;
		load_end = 1'b0;
		reset_dut();
		for (round = 0; round < 3; round++) begin
			build_alu_program();
			run_program("alu");
			reset_dut();
		end
		build_memory_program();
		run_program("memory");
		reset_dut();
		build_branch_program();
		run_program("branch");
		reset_dut();
		build_zero_program();
		run_program("register zero");
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_fetch.sv
logic/inst_decode.sv
logic/operand_fetch.sv
logic/execution.sv
logic/memory_access.sv
logic/write_back_pc_generate.sv
logic/cpu_top.sv
verification/cpu_asserts.sv
verification/cpu_tb.sv

// File: Makefile
TOP := cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
